//--- hw/smc_macros.svh
// Build-time bus widths and access timing; every phase count must fit in SMC_CNT_W bits
`ifndef SMC_MACROS_SVH
`define SMC_MACROS_SVH

// ----------------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------------
`define SMC_ADDR_W 32                  // AHB and external address
`define SMC_DATA_W 32                  // AHB and external data
`define SMC_BE_W (`SMC_DATA_W / 8)     // One enable per byte lane

// ----------------------------------------------------------------------------
// Access timing in hclk cycles
// ----------------------------------------------------------------------------
`define SMC_CSLE_CYCLES 1              // Chip select low before strobe
`define SMC_WS_CYCLES 2                // Wait states on top of the 1-cycle strobe
`define SMC_CSTE_CYCLES 1              // Chip select held after strobe, bus float

`define SMC_CNT_W 4                    // Phase down-counter width

// Cycles smc_hready is held low per transfer
// Lead + strobe (WS + 1) + trail + done
`define SMC_ACC_CYCLES (`SMC_CSLE_CYCLES + `SMC_WS_CYCLES + `SMC_CSTE_CYCLES + 2)

`endif

//--- hw/smc_pkg.sv
// Shared controller types; widths come from the build-time macros in smc_macros.svh
`default_nettype none

`include "smc_macros.svh"

package smc_pkg;

  // --------------------------------------------------------------------------
  // Data path types
  // --------------------------------------------------------------------------
  typedef logic [`SMC_DATA_W-1:0] smc_word_t;  // One bus word
  typedef logic [`SMC_BE_W-1:0]   smc_be_t;    // Byte enables, active low

  // Transfer size, same coding as hsize
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } smc_size_e;

  // --------------------------------------------------------------------------
  // Access sequencing
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    PH_IDLE   = 3'd0,   // No access
    PH_LEAD   = 3'd1,   // Chip select leading edge
    PH_STROBE = 3'd2,   // Read or write strobe plus wait states
    PH_TRAIL  = 3'd3,   // Chip select trailing edge
    PH_DONE   = 3'd4    // Completing cycle
  } smc_phase_e;

  // One external access as handed from the AHB side to the bus side
  typedef struct packed {
    logic [`SMC_ADDR_W-1:0] addr;    // Byte address
    smc_word_t              wdata;   // Write data, full word lanes
    smc_be_t                n_be;    // Lane enables, active low
    logic                   write;   // 1 write, 0 read
  } smc_req_t;

endpackage : smc_pkg

`default_nettype wire

//--- hw/smc_ahb_slave.sv
// AHB-lite slave with OKAY responses only; one access in flight, addresses must be size aligned
`default_nettype none

`include "smc_macros.svh"

module smc_ahb_slave
  import smc_pkg::*;
(
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  // AHB-lite slave side
  input  wire logic                   hsel,
  input  wire logic [`SMC_ADDR_W-1:0] haddr,
  input  wire logic [1:0]             htrans,
  input  wire logic                   hwrite,
  input  wire smc_size_e              hsize,
  input  wire smc_word_t              hwdata,
  input  wire logic                   hready,      // Muxed bus ready
  // From the access engine
  input  wire smc_word_t              rd_data,
  input  wire logic                   access_done,
  // To the access engine
  output smc_req_t                    req,
  output logic                        req_start,
  // AHB-lite response
  output logic                        smc_hready,
  output smc_word_t                   smc_hrdata
);

  logic                   accept;       // Valid address phase this cycle
  logic                   busy_q;       // Access in flight
  logic                   start_q;      // First data-phase cycle
  logic [`SMC_ADDR_W-1:0] addr_q;
  smc_size_e              size_q;
  logic                   write_q;
  smc_be_t                n_be;

  // NONSEQ (10) and SEQ (11) both have htrans[1] set
  assign accept = hsel & htrans[1] & hready;

  // --------------------------------------------------------------------------
  // Address phase capture
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;            // Pulse in first data phase
      if (accept)
        busy_q <= 1'b1;             // New transfer wins over the old completion
      else if (access_done)
        busy_q <= 1'b0;
    end
  end

  // Control of the pending transfer
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q  <= haddr;
      size_q  <= hsize;
      write_q <= hwrite;
    end
  end

  // --------------------------------------------------------------------------
  // Lane decode from low address bits and size
  // --------------------------------------------------------------------------
  always_comb begin
    n_be = '1;
    case (size_q)
      SIZE_BYTE: n_be[addr_q[1:0]] = 1'b0;     // Single lane
      SIZE_HALF: begin
        if (addr_q[1])
          n_be[3:2] = 2'b00;                   // Upper half
        else
          n_be[1:0] = 2'b00;                   // Lower half
      end
      default:   n_be = '0;                    // Word and anything wider
    endcase
  end

  // Write data joins in the data phase
  assign req = '{addr: addr_q, wdata: hwdata, n_be: n_be, write: write_q};
  assign req_start = start_q;

  // Low from the first data phase until the done cycle
  assign smc_hready = ~busy_q | access_done;
  assign smc_hrdata = rd_data;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Halfwords on even, words on multiple-of-four addresses
  a_aligned : assert property (@(posedge hclk) disable iff (!rst_n)
    accept |-> (((hsize == SIZE_HALF) -> !haddr[0]) &&
                ((hsize == SIZE_WORD) -> (haddr[1:0] == 2'b00))));

  // Wait state count seen by the master matches the engine timing
  a_ready_len : assert property (@(posedge hclk) disable iff (!rst_n)
    $fell(smc_hready) |-> !smc_hready [*`SMC_ACC_CYCLES] ##1 smc_hready);

endmodule : smc_ahb_slave

`default_nettype wire

//--- hw/smc_timing_fsm.sv
// Access phase sequencer; phase counts are build-time constants and must fit SMC_CNT_W bits
`default_nettype none

`include "smc_macros.svh"

module smc_timing_fsm
  import smc_pkg::*;
(
  input  wire logic hclk,
  input  wire logic rst_n,
  input  wire logic req_start,    // Only accepted in idle
  output smc_phase_e phase,
  output logic       access_done
);

  // --------------------------------------------------------------------------
  // Counter loads, one less than the phase length
  // --------------------------------------------------------------------------
  localparam int CNT_W   = `SMC_CNT_W;
  localparam int CSLE    = `SMC_CSLE_CYCLES;
  localparam int WS      = `SMC_WS_CYCLES;
  localparam int CSTE    = `SMC_CSTE_CYCLES;
  localparam int ACC_LEN = `SMC_ACC_CYCLES;

  localparam logic [CNT_W-1:0] CSLE_LD = CNT_W'((CSLE > 0) ? CSLE - 1 : 0);
  localparam logic [CNT_W-1:0] WS_LD   = CNT_W'(WS);          // Strobe is WS + 1 long
  localparam logic [CNT_W-1:0] CSTE_LD = CNT_W'((CSTE > 0) ? CSTE - 1 : 0);

  smc_phase_e       phase_q;
  smc_phase_e       phase_nxt;
  logic [CNT_W-1:0] cnt_q;          // Cycles left in current phase, minus one
  logic [CNT_W-1:0] cnt_nxt;
  logic             cnt_zero;

  assign cnt_zero = (cnt_q == '0);

  // --------------------------------------------------------------------------
  // Next phase and counter load
  // --------------------------------------------------------------------------
  always_comb begin
    phase_nxt = phase_q;
    cnt_nxt   = cnt_q;
    case (phase_q)
      PH_IDLE: begin
        if (req_start) begin
          if (CSLE > 0) begin
            phase_nxt = PH_LEAD;
            cnt_nxt   = CSLE_LD;
          end else begin
            phase_nxt = PH_STROBE;      // No leading edge, strobe at once
            cnt_nxt   = WS_LD;
          end
        end
      end
      PH_LEAD: begin
        if (cnt_zero) begin
          phase_nxt = PH_STROBE;
          cnt_nxt   = WS_LD;
        end else begin
          cnt_nxt = cnt_q - 1'b1;
        end
      end
      PH_STROBE: begin
        if (!cnt_zero) begin
          cnt_nxt = cnt_q - 1'b1;       // Wait states
        end else if (CSTE > 0) begin
          phase_nxt = PH_TRAIL;
          cnt_nxt   = CSTE_LD;
        end else begin
          phase_nxt = PH_DONE;          // No float time
        end
      end
      PH_TRAIL: begin
        if (cnt_zero)
          phase_nxt = PH_DONE;
        else
          cnt_nxt = cnt_q - 1'b1;
      end
      PH_DONE: phase_nxt = PH_IDLE;     // Always one idle cycle after done
      default: phase_nxt = PH_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PH_IDLE;
      cnt_q   <= '0;
    end else begin
      phase_q <= phase_nxt;
      cnt_q   <= cnt_nxt;
    end
  end

  assign phase       = phase_q;
  assign access_done = (phase_q == PH_DONE);    // Single cycle by construction

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Slave must not start a second access while one runs
  a_start_idle : assert property (@(posedge hclk) disable iff (!rst_n)
    req_start |-> (phase_q == PH_IDLE));

  // Exact busy length, then back to idle
  a_acc_len : assert property (@(posedge hclk) disable iff (!rst_n)
    req_start |=> (phase_q != PH_IDLE) [*ACC_LEN] ##1 (phase_q == PH_IDLE));

endmodule : smc_timing_fsm

`default_nettype wire

//--- hw/smc_strobe_gen.sv
// External bus driver; all strobes are registered and lag phase by one cycle, 32-bit bus only
`default_nettype none

`include "smc_macros.svh"

module smc_strobe_gen
  import smc_pkg::*;
(
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  input  wire logic                   req_start,
  input  wire smc_req_t               req,
  input  wire smc_phase_e             phase,
  input  wire smc_word_t              data_smc,    // Read data from memory
  // External memory bus
  output logic [`SMC_ADDR_W-1:0]      smc_addr,
  output smc_word_t                   smc_data,
  output smc_be_t                     smc_n_be,
  output logic                        smc_n_cs,
  output logic                        smc_n_rd,
  output logic                        smc_n_wr,
  output smc_be_t                     smc_n_we,
  output logic                        smc_n_ext_oe,
  // Back to the AHB side
  output smc_word_t                   rd_data
);

  localparam int WS = `SMC_WS_CYCLES;

  smc_req_t  req_q;       // Access being run
  smc_word_t rd_q;
  logic      cs_ph;       // Phase decodes, one cycle ahead of the pins
  logic      rd_ph;
  logic      wr_ph;
  logic      rd_latch;

  always_ff @(posedge hclk) begin
    if (req_start)
      req_q <= req;
  end

  assign cs_ph = (phase == PH_LEAD) | (phase == PH_STROBE) | (phase == PH_TRAIL);
  assign rd_ph = (phase == PH_STROBE) & ~req_q.write;
  assign wr_ph = (phase == PH_STROBE) &  req_q.write;

  // --------------------------------------------------------------------------
  // Registered strobes
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_ext_oe <= 1'b1;
    end else begin
      smc_n_cs     <= ~cs_ph;
      smc_n_rd     <= ~rd_ph;
      smc_n_wr     <= ~wr_ph;
      smc_n_we     <= wr_ph ? req_q.n_be : '1;           // Only enabled lanes
      smc_n_ext_oe <= ~(cs_ph & req_q.write);            // Drive data whole CS
    end
  end

  // Address and data hold between accesses, lanes only inside CS
  assign smc_addr = req_q.addr;
  assign smc_data = req_q.wdata;
  assign smc_n_be = smc_n_cs ? '1 : req_q.n_be;

  // --------------------------------------------------------------------------
  // Read capture
  // --------------------------------------------------------------------------
  // Last strobe cycle is the one where phase has already moved on
  assign rd_latch = ~smc_n_rd & (phase != PH_STROBE);

  always_ff @(posedge hclk) begin
    if (rd_latch)
      rd_q <= data_smc;
  end

  // Pass live data when done falls in the last strobe cycle (no trail)
  assign rd_data = rd_latch ? data_smc : rd_q;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  a_strobe_in_cs : assert property (@(posedge hclk) disable iff (!rst_n)
    (!smc_n_rd || !smc_n_wr || (smc_n_we != '1)) |-> !smc_n_cs);

  // Read strobe width as configured
  a_rd_width : assert property (@(posedge hclk) disable iff (!rst_n)
    $fell(smc_n_rd) |-> !smc_n_rd [*WS+1] ##1 smc_n_rd);

endmodule : smc_strobe_gen

`default_nettype wire

//--- hw/smc_lite.sv
// Static memory controller top; AHB-lite slave to a fixed 32-bit external bus, no config port
`default_nettype none

`include "smc_macros.svh"

module smc_lite
  import smc_pkg::*;
(
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  // AHB-lite
  input  wire logic                   hsel,
  input  wire logic [`SMC_ADDR_W-1:0] haddr,
  input  wire logic [1:0]             htrans,
  input  wire logic                   hwrite,
  input  wire smc_size_e              hsize,
  input  wire smc_word_t              hwdata,
  input  wire logic                   hready,
  output smc_word_t                   smc_hrdata,
  output logic                        smc_hready,
  // External memory bus
  input  wire smc_word_t              data_smc,
  output logic [`SMC_ADDR_W-1:0]      smc_addr,
  output smc_word_t                   smc_data,
  output smc_be_t                     smc_n_be,
  output logic                        smc_n_cs,
  output logic                        smc_n_wr,
  output smc_be_t                     smc_n_we,
  output logic                        smc_n_rd,
  output logic                        smc_n_ext_oe
);

  // --------------------------------------------------------------------------
  // Internal links
  // --------------------------------------------------------------------------
  smc_req_t   req;            // Access from the AHB side
  logic       req_start;      // Start pulse, first data phase
  smc_phase_e phase;
  logic       access_done;
  smc_word_t  rd_data;

  smc_ahb_slave smc_ahb_slave_i (
    .hclk        (hclk),
    .rst_n       (rst_n),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hsize       (hsize),
    .hwdata      (hwdata),
    .hready      (hready),
    .rd_data     (rd_data),
    .access_done (access_done),
    .req         (req),
    .req_start   (req_start),
    .smc_hready  (smc_hready),
    .smc_hrdata  (smc_hrdata)
  );

  smc_timing_fsm smc_timing_fsm_i (
    .hclk        (hclk),
    .rst_n       (rst_n),
    .req_start   (req_start),
    .phase       (phase),
    .access_done (access_done)
  );

  smc_strobe_gen smc_strobe_gen_i (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .req_start    (req_start),
    .req          (req),
    .phase        (phase),
    .data_smc     (data_smc),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_rd     (smc_n_rd),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we),
    .smc_n_ext_oe (smc_n_ext_oe),
    .rd_data      (rd_data)
  );

endmodule : smc_lite

`default_nettype wire

//--- verification/smc_lite_tb.sv
// Run from the project root; one slave so hready is smc_hready, memory model covers 1 KB only
`default_nettype none

`include "smc_macros.svh"

module smc_lite_tb
  import smc_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS     = 10;
  localparam int RST_CYCLES = 4;
  localparam int CSLE       = `SMC_CSLE_CYCLES;
  localparam int WS         = `SMC_WS_CYCLES;
  localparam int CSTE       = `SMC_CSTE_CYCLES;
  localparam int ACC_LEN    = CSLE + WS + CSTE + 2;   // Ready low per transfer
  localparam int CS_LEN     = CSLE + WS + 1 + CSTE;   // Chip select low per access
  localparam int MAX_PAT    = 64;

  logic                   hclk;
  logic                   rst_n;
  logic                   hsel;
  logic [`SMC_ADDR_W-1:0] haddr;
  logic [1:0]             htrans;
  logic                   hwrite;
  smc_size_e              hsize;
  smc_word_t              hwdata;
  logic                   hready;
  smc_word_t              smc_hrdata;
  logic                   smc_hready;
  smc_word_t              data_smc;
  logic [`SMC_ADDR_W-1:0] smc_addr;
  smc_word_t              smc_data;
  smc_be_t                smc_n_be;
  logic                   smc_n_cs;
  logic                   smc_n_wr;
  smc_be_t                smc_n_we;
  logic                   smc_n_rd;
  logic                   smc_n_ext_oe;

  // Pattern table
  logic                   pat_write [MAX_PAT];
  smc_size_e              pat_size  [MAX_PAT];
  logic [`SMC_ADDR_W-1:0] pat_addr  [MAX_PAT];
  smc_word_t              pat_wdata [MAX_PAT];
  smc_word_t              pat_rdata [MAX_PAT];
  int                     n_pat;
  bit                     loaded;

  smc_word_t mem [256];        // External memory, word per index
  smc_req_t  exp_q [$];        // Accesses the bus still owes
  smc_req_t  cur;              // Access under chip select
  int        acc_cnt;
  int        cs_len;
  int        stb_len;
  int        rdy_low;
  logic      cs_prev = 1'b1;
  logic      stb_prev = 1'b0;
  logic      stb_low;

  assign hready = smc_hready;    // Single slave on the bus

  smc_lite smc_lite_i (.*);

  initial begin
    hclk = 1'b0;
    forever #(CLK_NS / 2) hclk = ~hclk;
  end

  // --------------------------------------------------------------------------
  // Memory model, asynchronous read, lane writes
  // --------------------------------------------------------------------------
  assign data_smc = !smc_n_rd ? mem[smc_addr[9:2]] : '0;

  always @(posedge hclk) begin
    for (int b = 0; b < 4; b++)
      if (!smc_n_we[b])
        mem[smc_addr[9:2]][b*8 +: 8] <= smc_data[b*8 +: 8];
  end

  // --------------------------------------------------------------------------
  // Expected values and checks
  // --------------------------------------------------------------------------
  // Size in bytes is 1 << hsize, shifted up to the byte offset
  function automatic smc_be_t lanes_of(input smc_size_e size, input logic [1:0] offs);
    logic [7:0] mask;
    mask = ((8'd1 << (1 << size)) - 8'd1) << offs;
    return ~mask[3:0];
  endfunction

  function automatic smc_word_t lane_mask(input smc_be_t n_be);
    smc_word_t m;
    for (int b = 0; b < 4; b++)
      m[b*8 +: 8] = {8{~n_be[b]}};
    return m;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string name, input smc_word_t exp, input smc_word_t act);
    if (act !== exp)
      fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act));
  endtask

  task automatic check_be(input string name, input smc_be_t exp, input smc_be_t act);
    if (act !== exp)
      fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
      fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act));
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act));
  endtask

  // --------------------------------------------------------------------------
  // AHB master
  // --------------------------------------------------------------------------
  task automatic drive_addr(input int i);
    smc_req_t acc;
    acc.addr  = pat_addr[i];
    acc.wdata = pat_wdata[i];
    acc.n_be  = lanes_of(pat_size[i], pat_addr[i][1:0]);
    acc.write = pat_write[i];
    exp_q.push_back(acc);
    htrans <= 2'b10;                 // NONSEQ
    haddr  <= pat_addr[i];
    hwrite <= pat_write[i];
    hsize  <= pat_size[i];
  endtask

  // Samples mid-cycle, returns after the edge where ready was high
  task automatic wait_ready(output smc_word_t rdata);
    logic rdy;
    do begin
      @(negedge hclk);
      rdy   = smc_hready;
      rdata = smc_hrdata;
      @(posedge hclk);
    end while (!rdy);
  endtask

  // --------------------------------------------------------------------------
  // External bus and ready monitor
  // --------------------------------------------------------------------------
  always @(negedge hclk) begin
    if (rst_n) begin
      if (!smc_hready) begin
        rdy_low++;
      end else if (rdy_low > 0) begin
        check_count("smc_hready low cycles", ACC_LEN, rdy_low);
        rdy_low = 0;
      end
      stb_low = 1'b0;
      if (!smc_n_cs) begin
        if (cs_prev) begin                        // Chip select just fell
          if (exp_q.size() == 0)
            fail_run("An external access started with no AHB transfer pending");
          cur = exp_q.pop_front();
          acc_cnt++;
          cs_len  = 0;
          stb_len = 0;
        end
        stb_low = cur.write ? !smc_n_wr : !smc_n_rd;
        check_word("smc_addr", cur.addr, smc_addr);
        check_be("smc_n_be", cur.n_be, smc_n_be);
        check_level("smc_n_ext_oe", !cur.write, smc_n_ext_oe);
        if (cur.write)
          check_level("smc_n_rd", 1'b1, smc_n_rd);  // Wrong strobe kind
        else
          check_level("smc_n_wr", 1'b1, smc_n_wr);
        check_be("smc_n_we", (cur.write && stb_low) ? cur.n_be : '1, smc_n_we);
        if (cur.write && stb_low)
          check_word("smc_data", cur.wdata, smc_data);
        if (stb_low) begin
          if (stb_len == 0)
            check_count("strobe delay after chip select", CSLE, cs_len);
          else if (!stb_prev)
            fail_run("The strobe went low twice within one access");
          stb_len++;
        end
        cs_len++;
      end else begin
        if (!cs_prev) begin                       // Access just ended
          check_count("smc_n_cs low cycles", CS_LEN, cs_len);
          check_count("strobe low cycles", WS + 1, stb_len);
        end
        check_level("smc_n_rd", 1'b1, smc_n_rd);  // Quiet bus outside CS
        check_level("smc_n_wr", 1'b1, smc_n_wr);
        check_level("smc_n_ext_oe", 1'b1, smc_n_ext_oe);
        check_be("smc_n_we", '1, smc_n_we);
        check_be("smc_n_be", '1, smc_n_be);       // No lane enabled between accesses
      end
      cs_prev  = smc_n_cs;
      stb_prev = stb_low;
    end
  end

  // Budget per transfer is generous against the real 7 or 8 cycles
  initial begin
    wait (loaded);
    #((n_pat * (CSLE + WS + CSTE + 6) + RST_CYCLES) * CLK_NS);
    fail_run("Timeout: the transfers did not all complete in the time allowed");
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int                     fd;
    int                     code;
    int                     sz;
    byte                    dir;
    string                  line;
    logic [`SMC_ADDR_W-1:0] addr;
    smc_word_t              wd;
    smc_word_t              rd;
    smc_word_t              rdata;
    smc_word_t              m;
    rst_n  = 1'b0;
    hsel   = 1'b1;
    haddr  = '0;
    htrans = 2'b00;                  // IDLE
    hwrite = 1'b0;
    hsize  = SIZE_WORD;
    hwdata = '0;
    for (int i = 0; i < 256; i++)
      mem[i] = 32'hDEAD_0000 | i;    // Fill tracks the word index
    fd = $fopen("verification/smc_patterns.txt", "r");
    if (fd == 0)
      fail_run("Could not open verification/smc_patterns.txt");
    n_pat = 0;
    while ($fscanf(fd, " %c", dir) == 1) begin
      if (dir == "#") begin
        code = $fgets(line, fd);     // Skip comment line
      end else begin
        code = $fscanf(fd, "%d %h %h %h", sz, addr, wd, rd);
        if (code != 4)
          fail_run("A pattern line does not hold size, address, write and read data");
        pat_write[n_pat] = (dir == "W");
        pat_size[n_pat]  = smc_size_e'(sz);
        pat_addr[n_pat]  = addr;
        pat_wdata[n_pat] = wd;
        pat_rdata[n_pat] = rd;
        n_pat++;
      end
    end
    $fclose(fd);
    if (n_pat == 0)
      fail_run("The pattern file holds no transfers");
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge hclk);
    rst_n <= 1'b1;
    @(negedge hclk);
    check_level("smc_n_cs", 1'b1, smc_n_cs);
    check_level("smc_n_rd", 1'b1, smc_n_rd);
    check_level("smc_n_wr", 1'b1, smc_n_wr);
    check_level("smc_n_ext_oe", 1'b1, smc_n_ext_oe);
    check_be("smc_n_we", '1, smc_n_we);
    check_level("smc_hready", 1'b1, smc_hready);
    @(posedge hclk);
    drive_addr(0);
    wait_ready(rdata);               // Transfer 0 accepted
    for (int i = 0; i < n_pat; i++) begin
      hwdata <= pat_wdata[i];
      if (i + 1 < n_pat && i % 3 != 2)
        drive_addr(i + 1);           // Pipelined next address
      else
        htrans <= 2'b00;
      wait_ready(rdata);             // Transfer i completes here
      if (!pat_write[i]) begin
        m = lane_mask(lanes_of(pat_size[i], pat_addr[i][1:0]));
        check_word("smc_hrdata", pat_rdata[i] & m, rdata & m);
      end
      if (i + 1 < n_pat && i % 3 == 2) begin
        drive_addr(i + 1);           // After one IDLE cycle
        wait_ready(rdata);
      end
    end
    repeat (3) @(negedge hclk);
    check_count("external accesses", n_pat, acc_cnt);
    check_count("accesses still pending", 0, exp_q.size());
    $display("TB PASSED");
    $finish;
  end

endmodule : smc_lite_tb

`default_nettype wire

//--- flist.f
+incdir+hw
hw/smc_pkg.sv
hw/smc_ahb_slave.sv
hw/smc_timing_fsm.sv
hw/smc_strobe_gen.sv
hw/smc_lite.sv
verification/smc_lite_tb.sv

//--- verification/smc_patterns.txt
# dir(W/R) size(0 byte, 1 half, 2 word) addr(hex) wdata(hex) expected rdata(hex)
# Memory starts as DEAD0000 | word index, reads compare only the lanes of their size
W 2 00000010 11223344 00000000
R 2 00000010 00000000 11223344
W 0 00000012 55AA5555 00000000
R 2 00000010 00000000 11AA3344
W 1 00000012 BEEF7777 00000000
R 2 00000010 00000000 BEEF3344
W 1 00000020 9999CAFE 00000000
R 2 00000020 00000000 DEADCAFE
R 0 00000021 00000000 DEADCAFE
W 0 00000023 7F000000 00000000
W 0 00000020 00000001 00000000
R 2 00000020 00000000 7FADCA01
R 2 00000100 00000000 DEAD0040
R 1 00000102 00000000 DEAD0040
W 2 000003FC 0F0F0F0F 00000000
W 0 000003FD 0000A500 00000000
R 2 000003FC 00000000 0F0FA50F
R 2 00000004 00000000 DEAD0001
W 2 00000004 CAFEF00D 00000000
R 0 00000007 00000000 CAFEF00D
R 2 00000010 00000000 BEEF3344
